//--- files.f
+incdir+hdl
hdl/eth_tx_pkg.sv
hdl/tx_ctrl_if.sv
hdl/tx_seq_fsm.sv
hdl/phase_counter.sv
hdl/payload_buffer.sv
hdl/crc32_eth.sv
hdl/tx_byte_mux.sv
hdl/eth_tx_top.sv
testbench/tb_clk_gen.sv
testbench/tb_eth_tx.sv

//--- testbench/tb_eth_tx.sv
`timescale 1ns/1ps
`include "eth_tx_consts.svh"

module tb_eth_tx;
    import eth_tx_pkg::*;

    localparam int    NUM_ROWS      = 7;
    localparam int    TIMEOUT       = 200;
    localparam int    REQ_TO_VALID  = 2;
    localparam int    ACK_HOLD      = 3;
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam crc_t  REF_POLY      = 32'hEDB88320;

    logic  clk;
    logic  rst;
    logic  wr_en;
    byte_t wr_data;
    logic  req;
    logic  ack;
    logic  ready;
    byte_t tx_data;
    logic  tx_valid;

    integer seed = 32'h1f6d8701;
    byte_t  payload [`ETH_BUF_DEPTH];
    byte_t  fixed_data [10];

    // ==============================
    // Frame table
    // ==============================
    int   row_len    [NUM_ROWS];
    bit   row_random [NUM_ROWS];
    bit   row_junk   [NUM_ROWS];
    int   row_offset [NUM_ROWS];
    crc_t row_fcs    [NUM_ROWS];  // zero when no published check value

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    eth_tx_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .req      (req),
        .ack      (ack),
        .ready    (ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        if (got !== exp)
            fail_now($sformatf("Error at %0t: %s, got 8'h%02h, expected 8'h%02h",
                $time, what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("Error at %0t: %s, got %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_crc(input string what, input crc_t got, input crc_t exp);
        if (got !== exp)
            fail_now($sformatf("Error at %0t: %s, got %08h, expected %08h",
                $time, what, got, exp));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
            fail_now($sformatf("Error at %0t: %s, got %0d cycles, expected %0d",
                $time, what, got, exp));
    endtask

    // Bit-serial CRC-32 over the first n payload bytes taken LSB first
    function automatic crc_t ref_fcs(input int n);
        crc_t r;
        bit   fb;
        r = 32'hFFFFFFFF;
        for (int i = 0; i < n; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb = r[0] ^ payload[i][b];
                r  = r >> 1;
                if (fb) r = r ^ REF_POLY;
            end
        end
        return ~r;
    endfunction

    task automatic add_row(input int r, input int len, input bit rnd, input bit junk,
                           input int offset, input crc_t fcs);
        row_len[r]    = len;
        row_random[r] = rnd;
        row_junk[r]   = junk;
        row_offset[r] = offset;
        row_fcs[r]    = fcs;
    endtask

    // Host writes that the DUT should drop while busy
    task automatic drive_junk(input bit on);
        wr_en   = on;
        wr_data = on ? byte_t'($random(seed)) : '0;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_now("Timeout waiting for ready");
        end
    endtask

    task automatic run_frame(input int r);
        int    n;
        int    len;
        int    hdr;
        crc_t  fcs;
        byte_t exp;
        len = row_len[r];
        hdr = `ETH_PREAMBLE_LEN + 1;
        wait_ready();
        for (int i = 0; i < len; i++) begin
            payload[i] = row_random[r] ? byte_t'($random(seed)) : fixed_data[row_offset[r] + i];
        end
        fcs = ref_fcs(len);
        if (row_fcs[r] != '0) check_crc($sformatf("row %0d reference FCS", r), fcs, row_fcs[r]);

        for (int i = 0; i < len; i++) begin
            wr_en   = 1'b1;
            wr_data = payload[i];
            @(negedge clk);
        end
        wr_en = 1'b0;
        req   = 1'b1;

        n = 0;
        do begin
            @(negedge clk);
            n++;
            drive_junk(row_junk[r]);
            check_bit($sformatf("row %0d ready while busy", r), ready, 1'b0);
            if (n > TIMEOUT) fail_now("Timeout waiting for tx_valid");
        end while (!tx_valid);
        check_count($sformatf("row %0d req to first byte", r), n, REQ_TO_VALID);

        // ==============================
        // Line bytes arrive one per cycle
        // ==============================
        for (int k = 0; k < hdr + len + `ETH_FCS_LEN; k++) begin
            if (k > 0) @(negedge clk);
            drive_junk(row_junk[r] && k < `ETH_PREAMBLE_LEN);
            if (k < `ETH_PREAMBLE_LEN) exp = PREAMBLE_BYTE;
            else if (k == `ETH_PREAMBLE_LEN) exp = SFD_BYTE;
            else if (k < hdr + len) exp = payload[k - hdr];
            else exp = fcs[8 * (k - hdr - len) +: 8];
            check_bit($sformatf("row %0d byte %0d tx_valid", r, k), tx_valid, 1'b1);
            check_bit($sformatf("row %0d byte %0d ack", r, k), ack, 1'b0);
            check_byte($sformatf("row %0d byte %0d tx_data", r, k), tx_data, exp);
        end

        @(negedge clk);
        check_bit($sformatf("row %0d tx_valid after FCS", r), tx_valid, 1'b0);
        check_bit($sformatf("row %0d ack after FCS", r), ack, 1'b1);
        check_byte($sformatf("row %0d idle tx_data", r), tx_data, 8'h00);
        repeat (ACK_HOLD) begin
            @(negedge clk);
            check_bit($sformatf("row %0d ack held", r), ack, 1'b1);
        end
        req = 1'b0;

        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_now("Timeout waiting for ack to drop");
        end while (ack);
        check_count($sformatf("row %0d ack release", r), n, 1);

        // Gap writes must not reach the next frame
        n = 0;
        while (!ready) begin
            n++;
            drive_junk(row_junk[r]);
            @(negedge clk);
            if (n > TIMEOUT) fail_now("Timeout waiting for ready after the gap");
        end
        drive_junk(1'b0);
        check_count($sformatf("row %0d gap", r), n, `ETH_GAP_LEN);
    endtask

    initial begin
        int n;
        wr_en   = 1'b0;
        wr_data = '0;
        req     = 1'b0;
        fixed_data[0] = 8'hA5;
        for (int i = 0; i < 9; i++) begin
            fixed_data[1 + i] = byte_t'(8'h31 + i);
        end
        add_row(0, 1,  1'b0, 1'b0, 0, '0);
        add_row(1, 9,  1'b0, 1'b1, 1, 32'hCBF43926);
        add_row(2, 2,  1'b1, 1'b0, 0, '0);
        add_row(3, 17, 1'b1, 1'b1, 0, '0);
        add_row(4, 64, 1'b1, 1'b1, 0, '0);
        add_row(5, 17, 1'b1, 1'b0, 0, '0);
        add_row(6, 64, 1'b1, 1'b0, 0, '0);

        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) fail_now("Timeout waiting for reset release");
        end while (rst);
        check_bit("tx_valid after reset", tx_valid, 1'b0);
        check_bit("ack after reset", ack, 1'b0);
        check_byte("tx_data after reset", tx_data, 8'h00);
        wait_ready();

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_frame(r);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release halfway between rising edges
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
    end

endmodule

//--- hdl/eth_tx_top.sv
`timescale 1ns/1ps

module eth_tx_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  eth_tx_pkg::byte_t   wr_data,
    input  logic                req,
    output logic                ack,
    output logic                ready,
    output eth_tx_pkg::byte_t   tx_data,
    output logic                tx_valid
);
    import eth_tx_pkg::*;

    len_t  buf_len;
    len_t  idx;
    byte_t rd_data;
    byte_t fcs_byte;

    tx_ctrl_if ctrl_if ();

    tx_seq_fsm u_seq (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .ack     (ack),
        .ready   (ready),
        .buf_len (buf_len),
        .ctrl    (ctrl_if.seq)
    );

    phase_counter u_cnt (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl_if.counter),
        .idx  (idx)
    );

    payload_buffer u_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .ready   (ready),
        .ctrl    (ctrl_if.buffer),
        .rd_data (rd_data),
        .len     (buf_len)
    );

    crc32_eth u_crc (
        .clk      (clk),
        .rst      (rst),
        .data     (rd_data),
        .ctrl     (ctrl_if.crc),
        .idx      (idx),
        .fcs_byte (fcs_byte)
    );

    tx_byte_mux u_mux (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl_if.mux),
        .payload  (rd_data),
        .fcs_byte (fcs_byte),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

endmodule

//--- hdl/tx_byte_mux.sv
`timescale 1ns/1ps

module tx_byte_mux (
    input  logic                clk,
    input  logic                rst,
    tx_ctrl_if.mux              ctrl,
    input  eth_tx_pkg::byte_t   payload,
    input  eth_tx_pkg::byte_t   fcs_byte,
    output eth_tx_pkg::byte_t   tx_data,
    output logic                tx_valid
);
    import eth_tx_pkg::*;

    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_data  <= '0;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= 1'b1;
            case (ctrl.phase)
                PREAMBLE: tx_data <= PREAMBLE_BYTE;
                SFD:      tx_data <= SFD_BYTE;
                PAYLOAD:  tx_data <= payload;
                FCS:      tx_data <= fcs_byte;
                default: begin
                    tx_data  <= '0;
                    tx_valid <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- hdl/crc32_eth.sv
`timescale 1ns/1ps
`include "eth_tx_consts.svh"

module crc32_eth (
    input  logic                clk,
    input  logic                rst,
    input  eth_tx_pkg::byte_t   data,
    tx_ctrl_if.crc              ctrl,
    input  eth_tx_pkg::len_t    idx,
    output eth_tx_pkg::byte_t   fcs_byte
);
    import eth_tx_pkg::*;

    crc_t crc;
    crc_t fcs;
    len_t sel;

    // Reflected update shifts the low bit out first
    function automatic crc_t crc_next(input crc_t c_in, input byte_t d);
        crc_t c;
        c = c_in ^ crc_t'(d);
        for (int i = 0; i < 8; i++) begin
            if (c[0]) c = (c >> 1) ^ `ETH_CRC_POLY;
            else c = c >> 1;
        end
        return c;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc <= `ETH_CRC_INIT;
        end else if (ctrl.crc_clear) begin
            crc <= `ETH_CRC_INIT;
        end else if (ctrl.crc_en) begin
            crc <= crc_next(crc, data);
        end
    end

    // idx counts down, so the first FCS cycle picks the low byte
    assign fcs      = ~crc;
    assign sel      = len_t'(`ETH_FCS_LEN - 1) - idx;
    assign fcs_byte = fcs[8*sel[1:0] +: 8];

endmodule

//--- hdl/payload_buffer.sv
`timescale 1ns/1ps
`include "eth_tx_consts.svh"

module payload_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  eth_tx_pkg::byte_t   wr_data,
    input  logic                ready,
    tx_ctrl_if.buffer           ctrl,
    output eth_tx_pkg::byte_t   rd_data,
    output eth_tx_pkg::len_t    len
);
    import eth_tx_pkg::*;

    localparam int ADDR_W = $clog2(`ETH_BUF_DEPTH);

    byte_t mem [`ETH_BUF_DEPTH];
    len_t  wr_ptr;
    len_t  rd_ptr;
    logic  wr_ok;

    assign wr_ok = wr_en && ready && (wr_ptr < len_t'(`ETH_BUF_DEPTH));

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
        end
    end

    // ==============================
    // Pointers cleared during the gap
    // ==============================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (ctrl.phase == GAP) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + len_t'(1);
            if (ctrl.rd_en) rd_ptr <= rd_ptr + len_t'(1);
        end
    end

    assign rd_data = mem[rd_ptr[ADDR_W-1:0]];
    assign len     = wr_ptr;

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        wr_en && ready |-> wr_ptr < len_t'(`ETH_BUF_DEPTH))
        else $error("write beyond buffer depth");

    // Host writes while busy are dropped
    a_wr_when_ready: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> ready)
        else $warning("write ignored while not ready");

endmodule

//--- hdl/phase_counter.sv
`timescale 1ns/1ps

module phase_counter (
    input  logic                clk,
    input  logic                rst,
    tx_ctrl_if.counter          ctrl,
    output eth_tx_pkg::len_t    idx
);
    import eth_tx_pkg::*;

    len_t count;

    // Loads win over counting, and the count rests at zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (ctrl.cnt_load) begin
            count <= ctrl.cnt_value;
        end else if (count != '0) begin
            count <= count - len_t'(1);
        end
    end

    assign ctrl.cnt_zero = (count == '0);
    assign idx           = count;

endmodule

//--- hdl/tx_seq_fsm.sv
`timescale 1ns/1ps
`include "eth_tx_consts.svh"

module tx_seq_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    output logic                ack,
    output logic                ready,
    input  eth_tx_pkg::len_t    buf_len,
    tx_ctrl_if.seq              ctrl
);
    import eth_tx_pkg::*;

    tx_phase_t phase;
    tx_phase_t next_phase;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= IDLE;
        end else begin
            phase <= next_phase;
        end
    end

    // ==============================
    // Next phase and counter loads
    // ==============================
    always_comb begin
        next_phase     = phase;
        ctrl.cnt_load  = 1'b0;
        ctrl.cnt_value = '0;
        case (phase)
            IDLE: next_phase = WAIT;
            WAIT: begin
                if (req) begin
                    next_phase     = PREAMBLE;
                    ctrl.cnt_load  = 1'b1;
                    ctrl.cnt_value = len_t'(`ETH_PREAMBLE_LEN - 1);
                end
            end
            PREAMBLE: begin
                if (ctrl.cnt_zero) next_phase = SFD;
            end
            SFD: begin
                next_phase     = PAYLOAD;
                ctrl.cnt_load  = 1'b1;
                ctrl.cnt_value = buf_len - len_t'(1);
            end
            PAYLOAD: begin
                if (ctrl.cnt_zero) begin
                    next_phase     = FCS;
                    ctrl.cnt_load  = 1'b1;
                    ctrl.cnt_value = len_t'(`ETH_FCS_LEN - 1);
                end
            end
            FCS: begin
                // One spare cycle lets the last FCS byte leave the mux
                if (ctrl.cnt_zero) begin
                    next_phase     = DONE;
                    ctrl.cnt_load  = 1'b1;
                    ctrl.cnt_value = len_t'(1);
                end
            end
            DONE: begin
                if (ctrl.cnt_zero && !req) begin
                    next_phase     = GAP;
                    ctrl.cnt_load  = 1'b1;
                    ctrl.cnt_value = len_t'(`ETH_GAP_LEN - 1);
                end
            end
            GAP: begin
                if (ctrl.cnt_zero) next_phase = WAIT;
            end
            default: next_phase = IDLE;
        endcase
    end

    assign ctrl.phase     = phase;
    assign ctrl.rd_en     = (phase == PAYLOAD);
    assign ctrl.crc_en    = (phase == PAYLOAD);
    assign ctrl.crc_clear = (phase == SFD);
    assign ready          = (phase == WAIT);
    assign ack            = (phase == DONE) && ctrl.cnt_zero;

    // Ack only follows a request that was still up on the previous edge
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        ack |-> $past(req))
        else $error("ack high without req");

    a_req_nonempty: assert property (@(posedge clk) disable iff (rst)
        (phase == WAIT) && req |-> buf_len != '0)
        else $error("frame requested with empty buffer");

endmodule

//--- hdl/tx_ctrl_if.sv
`timescale 1ns/1ps

interface tx_ctrl_if;
    import eth_tx_pkg::*;

    tx_phase_t phase;
    logic      cnt_load;
    len_t      cnt_value;
    logic      cnt_zero;
    logic      rd_en;
    logic      crc_clear;
    logic      crc_en;

    modport seq (
        output phase, cnt_load, cnt_value, rd_en, crc_clear, crc_en,
        input  cnt_zero
    );

    modport counter (input cnt_load, cnt_value, output cnt_zero);

    modport buffer (input phase, rd_en);

    modport crc (input crc_clear, crc_en);

    modport mux (input phase);

endinterface

//--- hdl/eth_tx_pkg.sv
`include "eth_tx_consts.svh"

package eth_tx_pkg;

    typedef logic [7:0] byte_t;

    typedef logic [31:0] crc_t;

    // One extra bit so a full buffer length fits
    typedef logic [$clog2(`ETH_BUF_DEPTH):0] len_t;

    // Frame phases in transmit order
    typedef enum logic [2:0] {
        IDLE,
        WAIT,
        PREAMBLE,
        SFD,
        PAYLOAD,
        FCS,
        DONE,
        GAP
    } tx_phase_t;

endpackage

//--- hdl/eth_tx_consts.svh
`ifndef ETH_TX_CONSTS_SVH
`define ETH_TX_CONSTS_SVH

// ==============================
// Frame geometry
// ==============================
`define ETH_BUF_DEPTH    64
`define ETH_PREAMBLE_LEN 7
`define ETH_FCS_LEN      4
`define ETH_GAP_LEN      12

// ==============================
// Reflected Ethernet CRC-32
// ==============================
`define ETH_CRC_POLY     32'hEDB88320
`define ETH_CRC_INIT     32'hFFFFFFFF

`endif
